//--- src/rv_exec_settings.svh
`ifndef RV_EXEC_SETTINGS_SVH
`define RV_EXEC_SETTINGS_SVH

// datapath width of the execute stage
`define XLEN 64

// one shift-add step per multiplier bit
`define MUL_STEPS `XLEN

`endif

//--- src/rv_exec_pkg.sv
package rv_exec_pkg;

    // operations accepted at the issue port
    typedef enum logic [4:0] {
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        OP_AND  = 5'd2,
        OP_OR   = 5'd3,
        OP_XOR  = 5'd4,
        OP_SLL  = 5'd5,
        OP_SRL  = 5'd6,
        OP_SRA  = 5'd7,
        OP_SLT  = 5'd8,
        OP_SLTU = 5'd9,
        OP_BEQ  = 5'd10,  // branch compares only set cond
        OP_BNE  = 5'd11,
        OP_BLT  = 5'd12,
        OP_BGE  = 5'd13,
        OP_BLTU = 5'd14,
        OP_BGEU = 5'd15,
        OP_MUL  = 5'd16,  // low half of signed product
        OP_MULH = 5'd17   // high half
    } exec_op_e;

    // sequencer states
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_MUL  = 2'd1,  // waiting on the multiplier
        S_DONE = 2'd2   // alu result capture
    } seq_state_e;

    // which half of the 128-bit product goes out
    typedef enum logic {
        MUL_LO = 1'b0,
        MUL_HI = 1'b1
    } mul_mode_e;

endpackage

//--- src/mul_if.sv
`include "rv_exec_settings.svh"

interface mul_if;
    logic                  start;    // pulsed only while busy is low
    logic [`XLEN-1:0]      src1;
    logic [`XLEN-1:0]      src2;
    logic                  busy;
    logic                  done;     // one-cycle pulse
    logic [2*`XLEN-1:0]    product;  // held until the next start

    // sequencer side
    modport ctrl (
        output start, src1, src2,
        input  busy, done, product
    );

    // multiplier side
    modport unit (
        input  start, src1, src2,
        output busy, done, product
    );
endinterface

//--- src/alu_core.sv
`include "rv_exec_settings.svh"

module alu_core import rv_exec_pkg::*; (
    input  exec_op_e         op,
    input  logic             word,
    input  logic [`XLEN-1:0] src1,
    input  logic [`XLEN-1:0] src2,
    output logic [`XLEN-1:0] result,
    output logic             cond
);

    logic [`XLEN-1:0] sum;
    logic [`XLEN-1:0] diff;
    logic [`XLEN-1:0] sll_full;
    logic [5:0]       shamt;
    logic [31:0]      lo1;
    logic [31:0]      srl_w;
    logic [31:0]      sra_w;
    logic             eq;
    logic             lt_s;
    logic             lt_u;

    function automatic logic [`XLEN-1:0] sext32(input logic [31:0] v);
        return {{(`XLEN-32){v[31]}}, v};
    endfunction

    // word forms use only 5 bits of the amount
    assign shamt = word ? {1'b0, src2[4:0]} : src2[5:0];
    assign lo1   = src1[31:0];

    assign sum      = src1 + src2;
    assign diff     = src1 - src2;
    assign sll_full = src1 << shamt;  // low 32 bits double as the word result
    assign srl_w    = lo1 >> shamt[4:0];
    assign sra_w    = $signed(lo1) >>> shamt[4:0];  // sign taken from bit 31

    assign eq   = (src1 == src2);
    assign lt_s = ($signed(src1) < $signed(src2));
    assign lt_u = (src1 < src2);

    always_comb begin
        result = '0;
        cond   = 1'b0;
        case (op)
            OP_ADD:  result = word ? sext32(sum[31:0]) : sum;
            OP_SUB:  result = word ? sext32(diff[31:0]) : diff;
            OP_AND:  result = src1 & src2;
            OP_OR:   result = src1 | src2;
            OP_XOR:  result = src1 ^ src2;
            OP_SLL:  result = word ? sext32(sll_full[31:0]) : sll_full;
            OP_SRL: begin
                if (word) begin
                    result = sext32(srl_w);
                end else begin
                    result = src1 >> shamt;
                end
            end
            OP_SRA: begin
                if (word) begin
                    result = sext32(sra_w);
                end else begin
                    result = $signed(src1) >>> shamt;
                end
            end
            OP_SLT:  result = {{(`XLEN-1){1'b0}}, lt_s};
            OP_SLTU: result = {{(`XLEN-1){1'b0}}, lt_u};
            // compares leave result at zero
            OP_BEQ:  cond = eq;
            OP_BNE:  cond = ~eq;
            OP_BLT:  cond = lt_s;
            OP_BGE:  cond = ~lt_s;
            OP_BLTU: cond = lt_u;
            OP_BGEU: cond = ~lt_u;
            default: begin
                result = '0;  // multiplies are handled elsewhere
                cond   = 1'b0;
            end
        endcase
    end

endmodule

//--- src/seq_multiplier.sv
`include "rv_exec_settings.svh"

module seq_multiplier (
    input  logic clk,
    input  logic rst_n,
    mul_if.unit  mul
);

    localparam int CNT_W = $clog2(`MUL_STEPS);

    logic [`XLEN-1:0]   mcand;     // magnitude of src1 held for the run
    logic [2*`XLEN-1:0] acc;       // partial sum over the multiplier bits
    logic               neg;       // product sign
    logic [CNT_W-1:0]   step_cnt;
    logic [`XLEN-1:0]   mag1;
    logic [`XLEN-1:0]   mag2;
    logic [`XLEN-1:0]   step_mcand;
    logic [2*`XLEN-1:0] step_in;
    logic [2*`XLEN-1:0] step_out;
    logic [`XLEN:0]     part_sum;

    assign mag1 = mul.src1[`XLEN-1] ? -mul.src1 : mul.src1;
    assign mag2 = mul.src2[`XLEN-1] ? -mul.src2 : mul.src2;

    // first step runs straight off the incoming operands
    assign step_in    = mul.start ? {{`XLEN{1'b0}}, mag2} : acc;
    assign step_mcand = mul.start ? mag1 : mcand;

    // add on lsb then shift the whole pair right
    assign part_sum = {1'b0, step_in[2*`XLEN-1:`XLEN]}
                    + (step_in[0] ? {1'b0, step_mcand} : '0);
    assign step_out = {part_sum, step_in[`XLEN-1:1]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul.busy <= 1'b0;
            mul.done <= 1'b0;
            step_cnt <= '0;
        end else begin
            mul.done <= 1'b0;
            if (mul.start) begin
                mul.busy <= 1'b1;
                step_cnt <= CNT_W'(1);
            end else if (mul.busy) begin
                // done shows up with the final sum
                if (step_cnt == CNT_W'(`MUL_STEPS-1)) begin
                    mul.busy <= 1'b0;
                    mul.done <= 1'b1;
                end
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul.start) begin
            mcand <= mag1;
            neg   <= mul.src1[`XLEN-1] ^ mul.src2[`XLEN-1];
            acc   <= step_out;
        end else if (mul.busy) begin
            acc   <= step_out;
        end
    end

    // sign fixup on the magnitude product
    assign mul.product = neg ? -acc : acc;

endmodule

//--- src/exec_seq.sv
`include "rv_exec_settings.svh"

module exec_seq import rv_exec_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  exec_op_e         in_op,
    input  logic             in_word,
    input  logic [`XLEN-1:0] in_src1,
    input  logic [`XLEN-1:0] in_src2,
    output logic             in_ready,
    output exec_op_e         alu_op,
    output logic             alu_word,
    output logic [`XLEN-1:0] alu_src1,
    output logic [`XLEN-1:0] alu_src2,
    input  logic [`XLEN-1:0] alu_result,
    input  logic             alu_cond,
    mul_if.ctrl              mul,
    output logic             out_valid,
    output logic [`XLEN-1:0] out_result,
    output logic             out_cond
);

    seq_state_e       state;
    exec_op_e         op_q;
    logic             word_q;
    logic [`XLEN-1:0] src1_q;
    logic [`XLEN-1:0] src2_q;
    mul_mode_e        mode_q;
    logic             accept;
    logic             is_mul;

    assign in_ready = (state == S_IDLE) && !mul.busy;
    assign accept   = in_valid && in_ready;
    assign is_mul   = (in_op == OP_MUL) || (in_op == OP_MULH);

    // registered operands feed both units
    assign alu_op   = op_q;
    assign alu_word = word_q;
    assign alu_src1 = src1_q;
    assign alu_src2 = src2_q;
    assign mul.src1 = src1_q;
    assign mul.src2 = src2_q;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= in_op;
            word_q <= in_word;
            src1_q <= in_src1;
            src2_q <= in_src2;
            mode_q <= (in_op == OP_MULH) ? MUL_HI : MUL_LO;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            mul.start <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            mul.start <= 1'b0;
            out_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        if (is_mul) begin
                            state     <= S_MUL;
                            mul.start <= 1'b1;  // goes out the cycle after accept
                        end else begin
                            state <= S_DONE;
                        end
                    end
                end
                S_MUL: begin
                    if (mul.done) begin
                        out_valid <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
                S_DONE: begin
                    out_valid <= 1'b1;
                    state     <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // result holds until the next completion
    always_ff @(posedge clk) begin
        if (state == S_MUL && mul.done) begin
            out_result <= (mode_q == MUL_HI) ? mul.product[2*`XLEN-1:`XLEN]
                                             : mul.product[`XLEN-1:0];
            out_cond   <= 1'b0;
        end else if (state == S_DONE) begin
            out_result <= alu_result;
            out_cond   <= alu_cond;
        end
    end

endmodule

//--- src/exec_unit.sv
`include "rv_exec_settings.svh"

module exec_unit import rv_exec_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  exec_op_e         in_op,
    input  logic             in_word,
    input  logic [`XLEN-1:0] in_src1,
    input  logic [`XLEN-1:0] in_src2,
    output logic             in_ready,
    output logic             out_valid,
    output logic [`XLEN-1:0] out_result,
    output logic             out_cond
);

    exec_op_e         alu_op;
    logic             alu_word;
    logic [`XLEN-1:0] alu_src1;
    logic [`XLEN-1:0] alu_src2;
    logic [`XLEN-1:0] alu_result;
    logic             alu_cond;

    mul_if mul_bus ();  // sequencer to multiplier

    exec_seq u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_word    (in_word),
        .in_src1    (in_src1),
        .in_src2    (in_src2),
        .in_ready   (in_ready),
        .alu_op     (alu_op),
        .alu_word   (alu_word),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result),
        .alu_cond   (alu_cond),
        .mul        (mul_bus.ctrl),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_cond   (out_cond)
    );

    alu_core u_alu (
        .op     (alu_op),
        .word   (alu_word),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result),
        .cond   (alu_cond)
    );

    seq_multiplier u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .mul   (mul_bus.unit)
    );

endmodule

//--- verif/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// expected result with word forms on the low 32 bits
function automatic logic [`XLEN-1:0] model_result(input exec_op_e op, input logic word,
                                                  input logic [`XLEN-1:0] a,
                                                  input logic [`XLEN-1:0] b);
    logic signed [`XLEN-1:0]   sa;
    logic signed [`XLEN-1:0]   sb;
    logic signed [2*`XLEN-1:0] prod;
    logic [31:0]               rw;
    logic [`XLEN-1:0]          r;
    sa   = a;
    sb   = b;
    prod = (2*`XLEN)'(sa) * (2*`XLEN)'(sb);  // full signed product
    r    = '0;
    case (op)
        OP_ADD:  r = a + b;
        OP_SUB:  r = a - b;
        OP_AND:  r = a & b;
        OP_OR:   r = a | b;
        OP_XOR:  r = a ^ b;
        OP_SLL:  r = a << b[5:0];
        OP_SRL:  r = a >> b[5:0];
        OP_SRA:  r = sa >>> b[5:0];
        OP_SLT:  r[0] = sa < sb;
        OP_SLTU: r[0] = a < b;
        OP_MUL:  r = prod[`XLEN-1:0];
        OP_MULH: r = prod[2*`XLEN-1:`XLEN];
        default: r = '0;  // branches give zero
    endcase
    case (op)
        OP_ADD:  rw = a[31:0] + b[31:0];
        OP_SUB:  rw = a[31:0] - b[31:0];
        OP_SLL:  rw = a[31:0] << b[4:0];
        OP_SRL:  rw = a[31:0] >> b[4:0];
        OP_SRA:  rw = $signed(a[31:0]) >>> b[4:0];
        default: rw = '0;
    endcase
    if (word && op inside {OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA}) begin
        r = {{(`XLEN-32){rw[31]}}, rw};
    end
    return r;
endfunction

// branch condition flag
function automatic logic model_cond(input exec_op_e op, input logic [`XLEN-1:0] a,
                                    input logic [`XLEN-1:0] b);
    case (op)
        OP_BEQ:  return a == b;
        OP_BNE:  return a != b;
        OP_BLT:  return $signed(a) < $signed(b);
        OP_BGE:  return $signed(a) >= $signed(b);
        OP_BLTU: return a < b;
        OP_BGEU: return a >= b;
        default: return 1'b0;
    endcase
endfunction

`endif

//--- verif/exec_unit_tb.sv
`include "rv_exec_settings.svh"

module exec_unit_tb import rv_exec_pkg::*; ();

    localparam int NUM_TXN    = 400;
    localparam int RST_CYCLES = 16;
    localparam int MAX_CYCLES = NUM_TXN * (`MUL_STEPS + 4) + RST_CYCLES;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    exec_op_e         in_op;
    logic             in_word;
    logic [`XLEN-1:0] in_src1;
    logic [`XLEN-1:0] in_src2;
    logic             in_ready;
    logic             out_valid;
    logic [`XLEN-1:0] out_result;
    logic             out_cond;
    integer           seed;
    int               errors;
    int               cycles = 0;
    exec_op_e         cur_op;
    logic             cur_word;
    logic [`XLEN-1:0] cur_a;
    logic [`XLEN-1:0] cur_b;
    exec_op_e         nxt_op;    // op held on the inputs during a multiply
    logic             nxt_word;
    logic [`XLEN-1:0] nxt_a;
    logic [`XLEN-1:0] nxt_b;
    logic             have_next;

    `include "exec_model.svh"

    exec_unit u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_word    (in_word),
        .in_src1    (in_src1),
        .in_src2    (in_src2),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_cond   (out_cond)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // corner values mixed into random ones
    function automatic logic [`XLEN-1:0] pick_operand();
        logic [`XLEN-1:0] v;
        v = {$random(seed), $random(seed)};
        case ($unsigned($random(seed)) % 8)
            0: v = '0;
            1: v = {1'b1, {(`XLEN-1){1'b0}}};  // most negative
            2: v = '1;
            3: v[31] = 1'b1;
            4: v[`XLEN-1] = 1'b1;
            5: v[`XLEN-1:8] = '0;  // small positive
            default: ;
        endcase
        return v;
    endfunction

    task automatic pick_txn(output exec_op_e op, output logic word,
                            output logic [`XLEN-1:0] a, output logic [`XLEN-1:0] b);
        int sel;
        int r;
        sel  = $unsigned($random(seed)) % 18;
        r    = $random(seed);
        op   = exec_op_e'(sel);
        a    = pick_operand();
        b    = pick_operand();
        word = 1'b0;
        if (op inside {OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA, OP_MUL, OP_MULH}) begin
            word = r[0];
        end
        if (r[3:1] < 3'd2) begin
            b = a;  // equal operands now and then
        end
    endtask

    task automatic run_txn(input exec_op_e op, input logic word, input logic [`XLEN-1:0] a,
                           input logic [`XLEN-1:0] b, input logic hold_next);
        logic [`XLEN-1:0] exp_res;
        logic             exp_cond;
        logic             is_mul;
        int               lat;
        string            name;
        exp_res  = model_result(op, word, a, b);
        exp_cond = model_cond(op, a, b);
        is_mul   = (op == OP_MUL) || (op == OP_MULH);
        name     = $sformatf("%s word=%0d", op.name(), word);
        while (!in_ready) @(negedge clk);
        in_valid = 1'b1;
        in_op    = op;
        in_word  = word;
        in_src1  = a;
        in_src2  = b;
        @(negedge clk);
        lat      = 1;
        in_valid = 1'b0;
        if (is_mul && hold_next) begin
            pick_txn(nxt_op, nxt_word, nxt_a, nxt_b);
            have_next = 1'b1;
            in_valid  = 1'b1;  // must wait until ready returns
            in_op     = nxt_op;
            in_word   = nxt_word;
            in_src1   = nxt_a;
            in_src2   = nxt_b;
        end
        while (!out_valid) begin
            assert (!in_ready) else begin
                $display("in_ready went high before out_valid during %s", name);
                errors++;
            end
            @(negedge clk);
            lat++;
        end
        assert (out_result == exp_res) else begin
            $display("Error %s result: expected %h, actual %h", name, exp_res, out_result);
            errors++;
        end
        assert (out_cond == exp_cond) else begin
            $display("Error %s cond: expected %0d, actual %0d", name, exp_cond, out_cond);
            errors++;
        end
        if (!is_mul) begin
            assert (lat == 2) else begin
                $display("Error %s latency: expected 2, actual %0d", name, lat);
                errors++;
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_op     = OP_ADD;
        in_word   = 1'b0;
        in_src1   = '0;
        in_src2   = '0;
        seed      = 17;
        errors    = 0;
        have_next = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (in_ready && !out_valid) else begin
            $display("after reset in_ready is not high or out_valid is not low");
            errors++;
        end
        for (int i = 0; i < NUM_TXN; i++) begin
            if (have_next) begin
                cur_op    = nxt_op;
                cur_word  = nxt_word;
                cur_a     = nxt_a;
                cur_b     = nxt_b;
                have_next = 1'b0;
            end else begin
                pick_txn(cur_op, cur_word, cur_a, cur_b);
            end
            run_txn(cur_op, cur_word, cur_a, cur_b, i < NUM_TXN - 1);
        end
        in_valid = 1'b0;
        repeat (2) @(negedge clk);
        $display("%0d transactions, %0d error(s)", NUM_TXN, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- exec_unit.f
+incdir+src
+incdir+verif
src/rv_exec_pkg.sv
src/mul_if.sv
src/alu_core.sv
src/seq_multiplier.sv
src/exec_seq.sv
src/exec_unit.sv
verif/exec_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the exec_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f exec_unit.f --top-module exec_unit_tb \
    --Mdir obj_dir -o exec_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/exec_unit_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
exit 1
